/* source/eth_frame_pkg.sv */
`default_nettype none

package eth_frame_pkg;

	typedef logic [47:0] mac_addr_t;
	typedef logic [31:0] ip_addr_t;

	// Header fields taken over by the transmitter at frame start
	typedef struct packed {
		mac_addr_t   mac_dst;
		mac_addr_t   mac_src;
		ip_addr_t    ip_src;
		ip_addr_t    ip_dst;
		logic [15:0] udp_src;
		logic [15:0] udp_dst;
		logic [7:0]  ttl;
		logic [15:0] ip_id;
	} hdr_fields_t;

	// The state names the kind of byte now on txd
	typedef enum logic [3:0] {
		IDLE,
		PRE,
		SFD,
		ETH_HDR,
		IP_HDR,
		UDP_HDR,
		LINE_HDR,
		PAYLOAD,
		FCS,
		IFG
	} tx_state_t;

	// --------------------
	// Frame layout
	// --------------------
	localparam int PREAMBLE_BYTES = 7;
	localparam int IFG_BYTES      = 12;
	localparam int ETH_HDR_BYTES  = 14;
	localparam int IP_HDR_BYTES   = 20;
	localparam int UDP_HDR_BYTES  = 8;
	localparam int LINE_HDR_BYTES = 4;
	localparam int FCS_BYTES      = 4;

	localparam logic [7:0]  PREAMBLE_BYTE = 8'h55;
	localparam logic [7:0]  SFD_BYTE      = 8'hd5;
	localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;

	// Fixed IPv4 fields, version 4 with a 20 byte header
	localparam logic [7:0]  IP_VER_IHL   = 8'h45;
	localparam logic [15:0] IP_FLAGS_DF  = 16'h4000;
	localparam logic [7:0]  IP_PROTO_UDP = 8'h11;

endpackage

`default_nettype wire

/* source/video_line_pkg.sv */
`default_nettype none

package video_line_pkg;

	// Selects which byte pair of a pixel word goes out
	typedef enum logic {
		MODE_YUV = 1'b0,
		MODE_RGB = 1'b1
	} color_mode_t;

	// Head word of every packet
	typedef struct packed {
		logic [15:0] line_num;
		logic [15:0] x_pos;
		logic [15:0] unused;
	} line_hdr_t;

	// All later words of the packet
	typedef struct packed {
		logic [7:0]  y;
		logic [7:0]  c;
		logic [7:0]  g;
		logic [7:0]  r;
		logic [15:0] unused;
	} pix_word_t;

	typedef union packed {
		line_hdr_t hdr;
		pix_word_t pix;
	} pixel_word_u;

endpackage

`default_nettype wire

/* source/frame_crc32.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_crc32 (
	input  wire        fifo_clk,
	input  wire        sys_rst,
	input  wire        crc_init,
	input  wire        crc_en,
	input  wire  [7:0] data,
	output logic [31:0] fcs
);

	localparam logic [31:0] POLY = 32'h04C11DB7;

	logic [31:0] crc_q;
	logic [31:0] crc_next;
	logic [31:0] crc_cur;

	// One byte through the shift register, bit 0 enters first as on the wire
	function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] d);
		logic [31:0] c;
		logic        fb;
		c = crc;
		for (int i = 0; i < 8; i++) begin
			fb = c[31] ^ d[i];
			c = {c[30:0], 1'b0};
			if (fb)
				c = c ^ POLY;
		end
		return c;
	endfunction

	assign crc_next = crc_byte(crc_q, data);

	always_ff @(posedge fifo_clk) begin
		if (sys_rst || crc_init) begin
			crc_q <= '1;
		end else if (crc_en) begin
			crc_q <= crc_next;
		end
	end

	// Includes the byte still on the bus, so the first FCS byte is ready in time
	assign crc_cur = crc_en ? crc_next : crc_q;

	always_comb begin
		for (int i = 0; i < 32; i++) begin
			fcs[i] = ~crc_cur[31 - i];
		end
	end

endmodule

`default_nettype wire

/* source/ip_header_sum.sv */
`timescale 1ns/1ps
`default_nettype none

module ip_header_sum
	import eth_frame_pkg::*;
(
	input  wire              fifo_clk,
	input  wire              sys_rst,
	input  wire              sum_start,
	input  wire hdr_fields_t hdr,
	input  wire       [15:0] total_len,
	output logic      [15:0] sum_value,
	output logic             sum_valid
);

	localparam logic [2:0] LAST_STEP = 3'd5;

	logic [2:0]  step;
	logic [19:0] acc;
	logic [15:0] ip_id_q;
	logic [7:0]  ttl_q;
	ip_addr_t    ip_src_q;
	ip_addr_t    ip_dst_q;
	logic [15:0] word_a;
	logic [15:0] word_b;
	logic [16:0] fold_1;
	logic [15:0] fold_2;

	// Two halfwords per step, the checksum field itself counts as zero
	always_comb begin
		case (step)
			3'd1: begin
				word_a = ip_id_q;
				word_b = IP_FLAGS_DF;
			end
			3'd2: begin
				word_a = {ttl_q, IP_PROTO_UDP};
				word_b = ip_src_q[31:16];
			end
			3'd3: begin
				word_a = ip_src_q[15:0];
				word_b = ip_dst_q[31:16];
			end
			3'd4: begin
				word_a = ip_dst_q[15:0];
				word_b = 16'h0000;
			end
			default: begin
				word_a = 16'h0000;
				word_b = 16'h0000;
			end
		endcase
	end

	// End-around carry, folded twice
	assign fold_1 = {1'b0, acc[15:0]} + {13'd0, acc[19:16]};
	assign fold_2 = fold_1[15:0] + {15'd0, fold_1[16]};

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			step      <= 3'd0;
			sum_valid <= 1'b0;
		end else if (sum_start) begin
			step      <= 3'd1;
			sum_valid <= 1'b0;
		end else if (step == LAST_STEP) begin
			step      <= 3'd0;
			sum_valid <= 1'b1;
		end else if (step != 3'd0) begin
			step <= step + 3'd1;
		end
	end

	always_ff @(posedge fifo_clk) begin
		if (sum_start) begin
			// Version word and total length go in with the snapshot
			acc      <= {4'd0, IP_VER_IHL, 8'h00} + {4'd0, total_len};
			ip_id_q  <= hdr.ip_id;
			ttl_q    <= hdr.ttl;
			ip_src_q <= hdr.ip_src;
			ip_dst_q <= hdr.ip_dst;
		end else if (step != 3'd0 && step != LAST_STEP) begin
			acc <= acc + {4'd0, word_a} + {4'd0, word_b};
		end
		if (step == LAST_STEP)
			sum_value <= ~fold_2;
	end

endmodule

`default_nettype wire

/* source/tx_config_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_config_regs
	import eth_frame_pkg::*;
	import video_line_pkg::*;
#(
	parameter mac_addr_t   RESET_MAC_DST = 48'h0023_4567_8902,
	parameter mac_addr_t   RESET_MAC_SRC = 48'h0023_4567_8901,
	parameter ip_addr_t    RESET_IP_SRC  = {8'd192, 8'd168, 8'd0, 8'd1},
	parameter ip_addr_t    RESET_IP_DST  = {8'd192, 8'd168, 8'd0, 8'd2},
	parameter logic [15:0] RESET_UDP_SRC = 16'd12344,
	parameter logic [15:0] RESET_UDP_DST = 16'd12345,
	parameter logic [7:0]  RESET_TTL     = 8'h40,
	parameter logic [7:0]  RESET_ID      = 8'h00,
	parameter color_mode_t RESET_MODE    = MODE_YUV,
	parameter logic [15:0] IP_IDENT      = 16'h0000
) (
	input  wire               fifo_clk,
	input  wire               sys_rst,
	input  wire               cfg_wr,
	input  wire         [2:0] cfg_addr,
	input  wire        [31:0] cfg_data,
	output hdr_fields_t       hdr,
	output color_mode_t       mode
);

	mac_addr_t   mac_dst_q;
	mac_addr_t   mac_src_q;
	ip_addr_t    ip_src_q;
	ip_addr_t    ip_dst_q;
	logic [15:0] udp_src_q;
	logic [15:0] udp_dst_q;
	logic [7:0]  ttl_q;
	logic [7:0]  id_q;
	color_mode_t mode_q;

	// --------------------
	// Register map
	// 0/1 dst MAC [47:32] / [31:0], 2/3 src MAC the same way
	// 4 src IP, 5 dst IP, 6 {src port, dst port}
	// 7 mode in bit 16, id in [15:8], TTL in [7:0]
	// --------------------
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			mac_dst_q <= RESET_MAC_DST;
			mac_src_q <= RESET_MAC_SRC;
			ip_src_q  <= RESET_IP_SRC;
			ip_dst_q  <= RESET_IP_DST;
			udp_src_q <= RESET_UDP_SRC;
			udp_dst_q <= RESET_UDP_DST;
			ttl_q     <= RESET_TTL;
			id_q      <= RESET_ID;
			mode_q    <= RESET_MODE;
		end else if (cfg_wr) begin
			case (cfg_addr)
				3'd0: mac_dst_q[47:32] <= cfg_data[15:0];
				3'd1: mac_dst_q[31:0]  <= cfg_data;
				3'd2: mac_src_q[47:32] <= cfg_data[15:0];
				3'd3: mac_src_q[31:0]  <= cfg_data;
				3'd4: ip_src_q         <= cfg_data;
				3'd5: ip_dst_q         <= cfg_data;
				3'd6: begin
					udp_src_q <= cfg_data[31:16];
					udp_dst_q <= cfg_data[15:0];
				end
				default: begin
					mode_q <= color_mode_t'(cfg_data[16]);
					id_q   <= cfg_data[15:8];
					ttl_q  <= cfg_data[7:0];
				end
			endcase
		end
	end

	// Board id moves the low address bytes, wrapping mod 256
	always_comb begin
		hdr.mac_dst = {mac_dst_q[47:8], mac_dst_q[7:0] - id_q};
		hdr.mac_src = {mac_src_q[47:8], mac_src_q[7:0] + id_q};
		hdr.ip_src  = {ip_src_q[31:8], ip_src_q[7:0] + id_q};
		hdr.ip_dst  = {ip_dst_q[31:8], ip_dst_q[7:0] - id_q};
		hdr.udp_src = udp_src_q;
		hdr.udp_dst = udp_dst_q;
		hdr.ttl     = ttl_q;
		hdr.ip_id   = IP_IDENT;
	end

	assign mode = mode_q;

endmodule

`default_nettype wire

/* source/gmii_frame_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module gmii_frame_tx
	import eth_frame_pkg::*;
	import video_line_pkg::*;
#(
	parameter int PIXELS_PER_PACKET = 600
) (
	input  wire               fifo_clk,
	input  wire               sys_rst,
	input  wire hdr_fields_t  hdr,
	input  wire color_mode_t  mode,
	input  wire pixel_word_u  pixel_word,
	input  wire               fifo_empty,
	input  wire        [15:0] sum_value,
	input  wire               sum_valid,
	input  wire        [31:0] fcs,
	output logic              fifo_rd_en,
	output logic              sum_start,
	output logic       [15:0] total_len,
	output logic              crc_init,
	output logic              crc_en,
	output logic              tx_en,
	output logic        [7:0] txd
);

	localparam int          PAYLOAD_BYTES = 2 * PIXELS_PER_PACKET;
	localparam logic [15:0] UDP_LEN = 16'(UDP_HDR_BYTES + LINE_HDR_BYTES + PAYLOAD_BYTES);
	localparam logic [15:0] IP_LEN  = 16'(IP_HDR_BYTES) + UDP_LEN;

	tx_state_t   state;
	tx_state_t   nxt_state;
	logic [15:0] byte_cnt;
	logic [15:0] nxt_cnt;
	logic [7:0]  nxt_byte;
	logic        frame_start;

	hdr_fields_t hdr_q;
	color_mode_t mode_q;
	logic [15:0] ip_csum_q;

	logic [111:0] eth_vec;
	logic [159:0] ip_vec;
	logic [63:0]  udp_vec;
	logic [31:0]  line_vec;
	logic [7:0]   pix_first;
	logic [7:0]   pix_second;

	// Index of the last byte of each section
	function automatic logic [15:0] last_index(input tx_state_t s);
		case (s)
			PRE:      return 16'(PREAMBLE_BYTES - 1);
			ETH_HDR:  return 16'(ETH_HDR_BYTES - 1);
			IP_HDR:   return 16'(IP_HDR_BYTES - 1);
			UDP_HDR:  return 16'(UDP_HDR_BYTES - 1);
			LINE_HDR: return 16'(LINE_HDR_BYTES - 1);
			PAYLOAD:  return 16'(PAYLOAD_BYTES - 1);
			FCS:      return 16'(FCS_BYTES - 1);
			IFG:      return 16'(IFG_BYTES - 1);
			default:  return 16'd0;
		endcase
	endfunction

	assign frame_start = (state == IDLE) && !fifo_empty;
	assign sum_start   = frame_start;
	assign total_len   = IP_LEN;

	// --------------------
	// Next state
	// --------------------
	always_comb begin
		nxt_state = state;
		nxt_cnt   = byte_cnt + 16'd1;
		if (state == IDLE) begin
			nxt_cnt = 16'd0;
			if (!fifo_empty)
				nxt_state = PRE;
		end else if (byte_cnt == last_index(state)) begin
			nxt_cnt = 16'd0;
			case (state)
				PRE:      nxt_state = SFD;
				SFD:      nxt_state = ETH_HDR;
				ETH_HDR:  nxt_state = IP_HDR;
				IP_HDR:   nxt_state = UDP_HDR;
				UDP_HDR:  nxt_state = LINE_HDR;
				LINE_HDR: nxt_state = PAYLOAD;
				PAYLOAD:  nxt_state = FCS;
				FCS:      nxt_state = IFG;
				default:  nxt_state = IDLE;
			endcase
		end
	end

	// --------------------
	// Byte sources
	// --------------------
	assign eth_vec = {hdr_q.mac_dst, hdr_q.mac_src, ETH_TYPE_IPV4};
	assign ip_vec  = {IP_VER_IHL, 8'h00, IP_LEN, hdr_q.ip_id, IP_FLAGS_DF,
		hdr_q.ttl, IP_PROTO_UDP, ip_csum_q, hdr_q.ip_src, hdr_q.ip_dst};
	// UDP checksum left at zero
	assign udp_vec = {hdr_q.udp_src, hdr_q.udp_dst, UDP_LEN, 16'h0000};

	assign line_vec   = {pixel_word.hdr.line_num, pixel_word.hdr.x_pos};
	assign pix_first  = (mode_q == MODE_RGB) ? pixel_word.pix.g : pixel_word.pix.y;
	assign pix_second = (mode_q == MODE_RGB) ? pixel_word.pix.r : pixel_word.pix.c;

	// Picks the byte that goes on txd next cycle
	always_comb begin
		case (nxt_state)
			PRE:      nxt_byte = PREAMBLE_BYTE;
			SFD:      nxt_byte = SFD_BYTE;
			ETH_HDR:  nxt_byte = eth_vec[8 * (ETH_HDR_BYTES - 1 - nxt_cnt) +: 8];
			IP_HDR:   nxt_byte = ip_vec[8 * (IP_HDR_BYTES - 1 - nxt_cnt) +: 8];
			UDP_HDR:  nxt_byte = udp_vec[8 * (UDP_HDR_BYTES - 1 - nxt_cnt) +: 8];
			LINE_HDR: nxt_byte = line_vec[8 * (LINE_HDR_BYTES - 1 - nxt_cnt) +: 8];
			PAYLOAD:  nxt_byte = nxt_cnt[0] ? pix_second : pix_first;
			// Least significant FCS byte first
			FCS:      nxt_byte = fcs[8 * nxt_cnt[1:0] +: 8];
			default:  nxt_byte = 8'h00;
		endcase
	end

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			state    <= IDLE;
			byte_cnt <= 16'd0;
			tx_en    <= 1'b0;
			txd      <= 8'h00;
		end else begin
			state    <= nxt_state;
			byte_cnt <= nxt_cnt;
			tx_en    <= (nxt_state != IDLE) && (nxt_state != IFG);
			txd      <= nxt_byte;
		end
	end

	// Config is frozen for the whole frame
	always_ff @(posedge fifo_clk) begin
		if (frame_start) begin
			hdr_q  <= hdr;
			mode_q <= mode;
		end
		if (sum_valid)
			ip_csum_q <= sum_value;
	end

	// --------------------
	// FIFO and CRC control
	// --------------------
	// Pop while the last header byte or the second pixel byte is being loaded
	assign fifo_rd_en = ((state == LINE_HDR) && (byte_cnt == 16'(LINE_HDR_BYTES - 2))) ||
		((state == PAYLOAD) && !byte_cnt[0]);

	assign crc_init = (state == SFD);
	assign crc_en   = state inside {ETH_HDR, IP_HDR, UDP_HDR, LINE_HDR, PAYLOAD};

endmodule

`default_nettype wire

/* source/udp_video_tx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_video_tx_top
	import eth_frame_pkg::*;
	import video_line_pkg::*;
#(
	parameter int          PIXELS_PER_PACKET = 600,
	parameter mac_addr_t   RESET_MAC_DST     = 48'h0023_4567_8902,
	parameter mac_addr_t   RESET_MAC_SRC     = 48'h0023_4567_8901,
	parameter ip_addr_t    RESET_IP_SRC      = {8'd192, 8'd168, 8'd0, 8'd1},
	parameter ip_addr_t    RESET_IP_DST      = {8'd192, 8'd168, 8'd0, 8'd2},
	parameter logic [15:0] RESET_UDP_SRC     = 16'd12344,
	parameter logic [15:0] RESET_UDP_DST     = 16'd12345,
	parameter logic [7:0]  RESET_TTL         = 8'h40,
	parameter logic [7:0]  RESET_ID          = 8'h00,
	parameter color_mode_t RESET_MODE        = MODE_YUV,
	parameter logic [15:0] IP_IDENT          = 16'h0000
) (
	input  wire              fifo_clk,
	input  wire              sys_rst,
	input  wire              cfg_wr,
	input  wire        [2:0] cfg_addr,
	input  wire       [31:0] cfg_data,
	input  wire pixel_word_u pixel_word,
	input  wire              fifo_empty,
	output wire              fifo_rd_en,
	output wire              tx_en,
	output wire        [7:0] txd
);

	hdr_fields_t hdr;
	color_mode_t mode;
	wire         sum_start;
	wire         sum_valid;
	wire  [15:0] sum_value;
	wire  [15:0] total_len;
	wire         crc_init;
	wire         crc_en;
	wire  [31:0] fcs;

	tx_config_regs #(
		.RESET_MAC_DST (RESET_MAC_DST),
		.RESET_MAC_SRC (RESET_MAC_SRC),
		.RESET_IP_SRC  (RESET_IP_SRC),
		.RESET_IP_DST  (RESET_IP_DST),
		.RESET_UDP_SRC (RESET_UDP_SRC),
		.RESET_UDP_DST (RESET_UDP_DST),
		.RESET_TTL     (RESET_TTL),
		.RESET_ID      (RESET_ID),
		.RESET_MODE    (RESET_MODE),
		.IP_IDENT      (IP_IDENT)
	) tx_config_regs_inst (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.cfg_wr   (cfg_wr),
		.cfg_addr (cfg_addr),
		.cfg_data (cfg_data),
		.hdr      (hdr),
		.mode     (mode)
	);

	ip_header_sum ip_header_sum_inst (
		.fifo_clk  (fifo_clk),
		.sys_rst   (sys_rst),
		.sum_start (sum_start),
		.hdr       (hdr),
		.total_len (total_len),
		.sum_value (sum_value),
		.sum_valid (sum_valid)
	);

	// CRC runs on the bytes as they leave on txd
	frame_crc32 frame_crc32_inst (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.crc_init (crc_init),
		.crc_en   (crc_en),
		.data     (txd),
		.fcs      (fcs)
	);

	gmii_frame_tx #(
		.PIXELS_PER_PACKET (PIXELS_PER_PACKET)
	) gmii_frame_tx_inst (
		.fifo_clk   (fifo_clk),
		.sys_rst    (sys_rst),
		.hdr        (hdr),
		.mode       (mode),
		.pixel_word (pixel_word),
		.fifo_empty (fifo_empty),
		.sum_value  (sum_value),
		.sum_valid  (sum_valid),
		.fcs        (fcs),
		.fifo_rd_en (fifo_rd_en),
		.sum_start  (sum_start),
		.total_len  (total_len),
		.crc_init   (crc_init),
		.crc_en     (crc_en),
		.tx_en      (tx_en),
		.txd        (txd)
	);

endmodule

`default_nettype wire

/* bench/frame_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_checker #(
	parameter int FRAME_BYTES = 106,
	parameter int IFG_BYTES   = 12
) (
	input  wire                     fifo_clk,
	input  wire                     sys_rst,
	input  wire                     tx_en,
	input  wire               [7:0] txd,
	input  wire                     exp_load,
	input  wire [8*FRAME_BYTES-1:0] exp_frame,
	output int                      frames_started,
	output int                      frames_done,
	output int                      pass_count,
	output int                      fail_count
);

	// Byte offsets in the frame with the preamble included
	localparam int CRC_START = 8;
	localparam int IP_START  = 22;
	localparam int CSUM_POS  = IP_START + 10;
	localparam int FCS_POS   = FRAME_BYTES - 4;

	logic [7:0]               cap[$];
	logic [8*FRAME_BYTES-1:0] exp_q[$];
	logic [7:0]               exp_buf [FRAME_BYTES];
	int                       gap_cnt;
	int                       err_cnt;

	// Ones' complement sum of the expected IPv4 header with the checksum field as zero
	function automatic logic [15:0] calc_ip_csum();
		logic [31:0] s;
		s = 32'd0;
		for (int k = 0; k < 20; k += 2) begin
			if (k != 10)
				s = s + {16'd0, exp_buf[IP_START + k], exp_buf[IP_START + k + 1]};
		end
		s = {16'd0, s[15:0]} + {16'd0, s[31:16]};
		s = {16'd0, s[15:0]} + {16'd0, s[31:16]};
		return ~s[15:0];
	endfunction

	// Reflected CRC-32 from the destination MAC through the payload
	function automatic logic [31:0] calc_fcs();
		logic [31:0] c;
		c = 32'hffff_ffff;
		for (int k = CRC_START; k < FCS_POS; k++) begin
			c = c ^ {24'd0, exp_buf[k]};
			for (int b = 0; b < 8; b++)
				c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
		end
		return ~c;
	endfunction

	task automatic check_frame();
		logic [8*FRAME_BYTES-1:0] exp_bytes;
		logic [15:0]              csum_exp;
		logic [15:0]              csum_got;
		logic [31:0]              fcs_exp;
		logic [31:0]              fcs_got;
		if (exp_q.size() == 0) begin
			$display("Frame %0d arrived with no expected frame queued", frames_done);
			err_cnt++;
		end else begin
			exp_bytes = exp_q.pop_front();
			for (int k = 0; k < FRAME_BYTES; k++)
				exp_buf[k] = exp_bytes[8 * (FRAME_BYTES - 1 - k) +: 8];
			// Checksum goes into the expected header before the FCS is worked out
			csum_exp                = calc_ip_csum();
			exp_buf[CSUM_POS]     = csum_exp[15:8];
			exp_buf[CSUM_POS + 1] = csum_exp[7:0];
			fcs_exp                 = calc_fcs();
			if (cap.size() != FRAME_BYTES) begin
				$display("Frame %0d has %0d bytes with tx_en high, expected %0d",
					frames_done, cap.size(), FRAME_BYTES);
				err_cnt++;
			end else begin
				for (int k = 0; k < FCS_POS; k++) begin
					if (k != CSUM_POS && k != CSUM_POS + 1 && cap[k] !== exp_buf[k]) begin
						$display("MISMATCH txd byte %0d: got %h expected %h",
							k, cap[k], exp_buf[k]);
						err_cnt++;
					end
				end
				csum_got = {cap[CSUM_POS], cap[CSUM_POS + 1]};
				if (csum_got !== csum_exp) begin
					$display("MISMATCH ip_checksum: got %h expected %h", csum_got, csum_exp);
					err_cnt++;
				end
				// FCS leaves least significant byte first
				fcs_got = {cap[FCS_POS + 3], cap[FCS_POS + 2], cap[FCS_POS + 1], cap[FCS_POS]};
				if (fcs_got !== fcs_exp) begin
					$display("MISMATCH fcs: got %h expected %h", fcs_got, fcs_exp);
					err_cnt++;
				end
			end
		end
	endtask

	task automatic finish_frame();
		check_frame();
		if (err_cnt == 0) begin
			$display("Frame %0d: PASS", frames_done);
			pass_count++;
		end else begin
			$display("Frame %0d: FAIL with %0d errors", frames_done, err_cnt);
			fail_count++;
		end
		frames_done++;
		cap.delete();
		err_cnt = 0;
	endtask

	// --------------------
	// Capture and gap count
	// --------------------
	always @(posedge fifo_clk) begin
		if (sys_rst) begin
			cap.delete();
			exp_q.delete();
			gap_cnt        = 0;
			err_cnt        = 0;
			frames_started = 0;
			frames_done    = 0;
			pass_count     = 0;
			fail_count     = 0;
		end else begin
			if (exp_load)
				exp_q.push_back(exp_frame);
			if (tx_en) begin
				if (cap.size() != 0 && gap_cnt != 0) begin
					$display("Frame %0d: tx_en rose again after a gap of only %0d cycles",
						frames_done, gap_cnt);
					err_cnt++;
					finish_frame();
				end else if (cap.size() == 0 && frames_done != 0 &&
					gap_cnt != IFG_BYTES + 1) begin
					// Back-to-back frames keep the IFG plus one idle cycle between them
					$display("Frame %0d: tx_en rose after %0d low cycles, expected %0d",
						frames_done, gap_cnt, IFG_BYTES + 1);
					err_cnt++;
				end
				if (cap.size() == 0)
					frames_started++;
				gap_cnt = 0;
				cap.push_back(txd);
			end else if (cap.size() != 0 || frames_done != 0) begin
				gap_cnt++;
				if (cap.size() != 0 && gap_cnt == IFG_BYTES)
					finish_frame();
			end
		end
	end

endmodule

`default_nettype wire

/* bench/tb_udp_video_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_udp_video_tx
	import video_line_pkg::*;
();

	localparam int PIXELS         = 24;
	localparam int NUM_ROWS       = 4;
	localparam int IFG_BYTES      = 12;
	localparam int HDR_BYTES      = 54;
	localparam int FRAME_BYTES    = HDR_BYTES + 2 * PIXELS + 4;
	localparam int TIMEOUT_CYCLES = NUM_ROWS * (FRAME_BYTES + IFG_BYTES + 100);
	localparam logic [15:0] UDP_LEN = 16'(8 + 4 + 2 * PIXELS);
	localparam logic [15:0] IP_LEN  = 16'(20 + 8 + 4 + 2 * PIXELS);

	// One test row, the last four bytes are the low address bytes after the id
	typedef struct packed {
		logic [47:0] mac_dst;
		logic [47:0] mac_src;
		logic [31:0] ip_src;
		logic [31:0] ip_dst;
		logic [15:0] udp_src;
		logic [15:0] udp_dst;
		logic [7:0]  ttl;
		logic [7:0]  id;
		color_mode_t mode;
		logic [15:0] line_num;
		logic [15:0] x_pos;
		logic [7:0]  exp_mac_dst_lo;
		logic [7:0]  exp_mac_src_lo;
		logic [7:0]  exp_ip_src_lo;
		logic [7:0]  exp_ip_dst_lo;
	} test_row_t;

	logic                     fifo_clk;
	logic                     sys_rst;
	logic                     cfg_wr;
	logic [2:0]               cfg_addr;
	logic [31:0]              cfg_data;
	pixel_word_u              pixel_word;
	logic                     fifo_empty;
	wire                      fifo_rd_en;
	wire                      tx_en;
	wire  [7:0]               txd;
	logic                     exp_load;
	logic [8*FRAME_BYTES-1:0] exp_frame;
	int                       frames_started;
	int                       frames_done;
	int                       pass_count;
	int                       fail_count;
	int                       cycle_cnt = 0;
	integer                   seed;
	test_row_t                test_rows [NUM_ROWS];
	pixel_word_u              fifo_q[$];

	udp_video_tx_top #(
		.PIXELS_PER_PACKET (PIXELS)
	) udp_video_tx_top_inst (
		.fifo_clk   (fifo_clk),
		.sys_rst    (sys_rst),
		.cfg_wr     (cfg_wr),
		.cfg_addr   (cfg_addr),
		.cfg_data   (cfg_data),
		.pixel_word (pixel_word),
		.fifo_empty (fifo_empty),
		.fifo_rd_en (fifo_rd_en),
		.tx_en      (tx_en),
		.txd        (txd)
	);

	frame_checker #(
		.FRAME_BYTES (FRAME_BYTES),
		.IFG_BYTES   (IFG_BYTES)
	) frame_checker_inst (
		.fifo_clk       (fifo_clk),
		.sys_rst        (sys_rst),
		.tx_en          (tx_en),
		.txd            (txd),
		.exp_load       (exp_load),
		.exp_frame      (exp_frame),
		.frames_started (frames_started),
		.frames_done    (frames_done),
		.pass_count     (pass_count),
		.fail_count     (fail_count)
	);

	initial begin
		fifo_clk = 1'b0;
		forever #4 fifo_clk = ~fifo_clk;
	end

	// First-word-fall-through FIFO model
	always @(posedge fifo_clk) begin
		if (fifo_rd_en && fifo_q.size() > 0)
			fifo_q.delete(0);
		if (fifo_q.size() > 0) begin
			pixel_word <= fifo_q[0];
			fifo_empty <= 1'b0;
		end else begin
			pixel_word <= '0;
			fifo_empty <= 1'b1;
		end
	end

	always @(posedge fifo_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles with %0d of %0d frames checked",
				cycle_cnt, frames_done, NUM_ROWS);
			$display("Test failed");
			$finish;
		end
	end

	task automatic write_config(input test_row_t r);
		logic [31:0] words [8];
		words[0] = {16'd0, r.mac_dst[47:32]};
		words[1] = r.mac_dst[31:0];
		words[2] = {16'd0, r.mac_src[47:32]};
		words[3] = r.mac_src[31:0];
		words[4] = r.ip_src;
		words[5] = r.ip_dst;
		words[6] = {r.udp_src, r.udp_dst};
		words[7] = {15'd0, r.mode, r.id, r.ttl};
		for (int a = 0; a < 8; a++) begin
			@(posedge fifo_clk);
			cfg_wr   <= 1'b1;
			cfg_addr <= 3'(a);
			cfg_data <= words[a];
		end
		@(posedge fifo_clk);
		cfg_wr <= 1'b0;
	endtask

	// Fills the FIFO with one packet and hands its expected bytes to the checker
	task automatic queue_frame(input test_row_t r);
		logic [8*FRAME_BYTES-1:0] vec;
		logic [8*HDR_BYTES-1:0]   hdr_bytes;
		pixel_word_u              w;
		logic [47:0]              mac_dst;
		logic [47:0]              mac_src;
		logic [31:0]              ip_src;
		logic [31:0]              ip_dst;
		int                       pos;
		@(posedge fifo_clk);
		mac_dst = {r.mac_dst[47:8], r.exp_mac_dst_lo};
		mac_src = {r.mac_src[47:8], r.exp_mac_src_lo};
		ip_src  = {r.ip_src[31:8], r.exp_ip_src_lo};
		ip_dst  = {r.ip_dst[31:8], r.exp_ip_dst_lo};
		// Head word, unused bits stay random
		w = 48'({$random(seed), $random(seed)});
		w.hdr.line_num = r.line_num;
		w.hdr.x_pos    = r.x_pos;
		fifo_q.push_back(w);
		// IP checksum and FCS stay zero here, the checker recomputes both
		hdr_bytes = {{7{8'h55}}, 8'hd5, mac_dst, mac_src, 16'h0800,
			8'h45, 8'h00, IP_LEN, 16'h0000, 16'h4000, r.ttl, 8'h11, 16'h0000, ip_src, ip_dst,
			r.udp_src, r.udp_dst, UDP_LEN, 16'h0000, w.hdr.line_num, w.hdr.x_pos};
		vec = '0;
		vec[8*FRAME_BYTES-1 -: 8*HDR_BYTES] = hdr_bytes;
		pos = HDR_BYTES;
		for (int p = 0; p < PIXELS; p++) begin
			w = 48'({$random(seed), $random(seed)});
			fifo_q.push_back(w);
			vec[8 * (FRAME_BYTES - 1 - pos) +: 8] = (r.mode == MODE_RGB) ? w.pix.g : w.pix.y;
			vec[8 * (FRAME_BYTES - 2 - pos) +: 8] = (r.mode == MODE_RGB) ? w.pix.r : w.pix.c;
			pos = pos + 2;
		end
		exp_frame <= vec;
		exp_load  <= 1'b1;
		@(posedge fifo_clk);
		exp_load <= 1'b0;
	endtask

	initial begin
		sys_rst    = 1'b1;
		cfg_wr     = 1'b0;
		cfg_addr   = 3'd0;
		cfg_data   = 32'd0;
		pixel_word = '0;
		fifo_empty = 1'b1;
		exp_load   = 1'b0;
		exp_frame  = '0;
		seed       = 34;

		// --------------------
		// mac_dst, mac_src, ip_src, ip_dst, udp ports, ttl, id, mode, line, x,
		// expected low bytes {mac_dst, mac_src, ip_src, ip_dst}
		// --------------------
		test_rows[0] = {48'h0200_0000_0010, 48'h0200_0000_0020, 32'hc0a8_0a05, 32'hc0a8_0a06,
			16'h1f90, 16'h1f91, 8'h40, 8'h00, MODE_YUV, 16'h0001, 16'h0000, 32'h10_20_05_06};
		test_rows[1] = {48'h0200_0000_0010, 48'h0200_0000_0020, 32'hc0a8_0a05, 32'hc0a8_0a06,
			16'h3039, 16'h303a, 8'h20, 8'h01, MODE_RGB, 16'h0002, 16'h0018, 32'h0f_21_06_05};
		// id FF wraps both ways
		test_rows[2] = {48'h0a0b_0c0d_0e02, 48'h1a1b_1c1d_1e01, 32'h0a00_0001, 32'h0a00_0002,
			16'h0400, 16'h0401, 8'h80, 8'hff, MODE_YUV, 16'h0123, 16'h0030, 32'h03_00_00_03};
		test_rows[3] = {48'hffff_ffff_ff08, 48'h0011_2233_44f8, 32'hac10_00f5, 32'hac10_0003,
			16'hc000, 16'hc001, 8'h01, 8'h10, MODE_RGB, 16'habcd, 16'hfff0, 32'hf8_08_05_f3};

		repeat (4) @(posedge fifo_clk);
		sys_rst <= 1'b0;

		// Next config is written while the previous frame is still on the wire
		for (int i = 0; i < NUM_ROWS; i++) begin
			write_config(test_rows[i]);
			queue_frame(test_rows[i]);
			wait (frames_started == i + 1);
		end
		wait (frames_done == NUM_ROWS);

		$display("Frames passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0 && pass_count == NUM_ROWS) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* udp_video_tx.f */
source/eth_frame_pkg.sv
source/video_line_pkg.sv
source/frame_crc32.sv
source/ip_header_sum.sv
source/tx_config_regs.sv
source/gmii_frame_tx.sv
source/udp_video_tx_top.sv
bench/frame_checker.sv
bench/tb_udp_video_tx.sv

/* Bender.yml */
package:
  name: udp_video_tx

sources:
  - source/eth_frame_pkg.sv
  - source/video_line_pkg.sv
  - source/frame_crc32.sv
  - source/ip_header_sum.sv
  - source/tx_config_regs.sv
  - source/gmii_frame_tx.sv
  - source/udp_video_tx_top.sv
  - target: test
    files:
      - bench/frame_checker.sv
      - bench/tb_udp_video_tx.sv
